//--- hw/pack_pkg.sv
// frame constants, shared types and controller states for the telemetry packer
package pack_pkg;

	// --------------------
	// widths with a meaning
	// --------------------

	// one byte of the frame stream
	typedef logic [7:0] pk_byte_t;

	// utc seconds from the time source
	typedef logic [31:0] utc_t;

	// configuration word where bit 0 enables packing
	typedef logic [7:0] cfg_t;

	// running crc value
	typedef logic [15:0] crc_t;

	// payload memory address
	typedef logic [3:0] load_addr_t;

	// frame counter that wraps at 8 bits
	typedef logic [7:0] frm_cnt_t;

	// --------------------
	// frame layout
	// --------------------

	// sync word at the start of every frame
	localparam pk_byte_t SYNC_HI = 8'heb;
	localparam pk_byte_t SYNC_LO = 8'h90;

	// section lengths in bytes
	localparam int HEAD_LEN  = 8;
	localparam int LOAD_LEN  = 16;
	localparam int TAIL_LEN  = 2;
	localparam int CRC_LEN   = 2;
	localparam int FRAME_LEN = HEAD_LEN + LOAD_LEN + TAIL_LEN + CRC_LEN;

	// last byte of the tail
	localparam pk_byte_t END_MARK = 8'hd7;

	// crc-16-ccitt
	localparam crc_t CRC_POLY = 16'h1021;
	localparam crc_t CRC_INIT = 16'hffff;

	// --------------------
	// controller states
	// --------------------

	// fixed encodings with the crc states at the top
	typedef enum logic [3:0] {
		IDLE      = 4'h0,
		FIRE_HEAD = 4'h1,
		WAIT_HEAD = 4'h2,
		FIRE_LOAD = 4'h3,
		WAIT_LOAD = 4'h4,
		FIRE_TAIL = 4'h5,
		WAIT_TAIL = 4'h6,
		FIRE_CRC  = 4'hc,
		WAIT_CRC  = 4'hd,
		DONE      = 4'hf
	} st_pack_t;

endpackage

//--- hw/pack_sec_if.sv
// section lane between the controller, one section generator and the output stage
`timescale 1ns/100ps

interface pack_sec_if
	import pack_pkg::*;
();

	// one-cycle start pulse from the controller
	logic fire;

	// pulses with the last byte of the section
	logic done;

	// byte strobe and byte
	logic vld;
	pk_byte_t data;

	// controller side
	modport ctrl (
		output fire,
		input  done
	);

	// section generator side
	modport sec (
		input  fire,
		output done,
		output vld,
		output data
	);

	// output stage, listens only
	modport sink (
		input fire,
		input vld,
		input data
	);

endinterface

//--- hw/pack_main.sv
// frame controller that fires header, payload, tail and crc in turn and drives pk_frm
`timescale 1ns/100ps

module pack_main
	import pack_pkg::*;
(
	input  logic   clk_sys,
	input  logic   rst_n,
	input  cfg_t   cfg_pkg_en,
	input  logic   syn_vld,
	pack_sec_if.ctrl head,
	pack_sec_if.ctrl load,
	pack_sec_if.ctrl tail,
	pack_sec_if.ctrl crc,
	output logic   pk_frm
);

	logic pack_en;
	st_pack_t st_pack;

	assign pack_en = cfg_pkg_en[0];

	// --------------------
	// main fsm
	// --------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			st_pack <= IDLE;
		end else begin
			case (st_pack)
				IDLE:      st_pack <= (pack_en && syn_vld) ? FIRE_HEAD : IDLE;
				FIRE_HEAD: st_pack <= WAIT_HEAD;
				WAIT_HEAD: st_pack <= head.done ? FIRE_LOAD : WAIT_HEAD;
				FIRE_LOAD: st_pack <= WAIT_LOAD;
				WAIT_LOAD: st_pack <= load.done ? FIRE_TAIL : WAIT_LOAD;
				FIRE_TAIL: st_pack <= WAIT_TAIL;
				WAIT_TAIL: st_pack <= tail.done ? FIRE_CRC : WAIT_TAIL;
				FIRE_CRC:  st_pack <= WAIT_CRC;
				WAIT_CRC:  st_pack <= crc.done ? DONE : WAIT_CRC;
				// always back through idle
				DONE:      st_pack <= IDLE;
				default:   st_pack <= IDLE;
			endcase
		end
	end

	// --------------------
	// control outputs
	// --------------------

	assign head.fire = (st_pack == FIRE_HEAD);
	assign load.fire = (st_pack == FIRE_LOAD);
	assign tail.fire = (st_pack == FIRE_TAIL);
	assign crc.fire  = (st_pack == FIRE_CRC);

	// high for the whole frame since the last crc byte lands in DONE
	assign pk_frm = (st_pack != IDLE);

	// --------------------
	// checks
	// --------------------

	// a section may only finish while we wait for it
	a_done_state: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		(head.done -> st_pack == WAIT_HEAD) &&
		(load.done -> st_pack == WAIT_LOAD) &&
		(tail.done -> st_pack == WAIT_TAIL) &&
		(crc.done -> st_pack == WAIT_CRC)
	);

endmodule

//--- hw/pack_head.sv
// header section, sync word, frame counter, latched utc and payload length
`timescale 1ns/100ps

module pack_head
	import pack_pkg::*;
(
	input  logic clk_sys,
	input  logic rst_n,
	input  utc_t utc_sec,
	pack_sec_if.sec sec
);

	logic busy;
	logic [2:0] idx;
	utc_t utc_lat;
	frm_cnt_t frm_cnt;

	// byte index runs while busy
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			idx  <= '0;
		end else if (sec.fire) begin
			busy <= 1'b1;
			idx  <= '0;
		end else if (busy) begin
			idx <= idx + 3'd1;
			if (sec.done)
				busy <= 1'b0;
		end
	end

	// seconds are frozen for the whole header
	always_ff @(posedge clk_sys) begin
		if (sec.fire)
			utc_lat <= utc_sec;
	end

	// count finished headers, wraps at 8 bits
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			frm_cnt <= '0;
		else if (sec.done)
			frm_cnt <= frm_cnt + 8'd1;
	end

	assign sec.vld  = busy;
	assign sec.done = busy && (idx == 3'(HEAD_LEN - 1));

	// header byte select
	always_comb begin
		case (idx)
			3'd0:    sec.data = SYNC_HI;
			3'd1:    sec.data = SYNC_LO;
			3'd2:    sec.data = frm_cnt;
			3'd3:    sec.data = utc_lat[31:24];
			3'd4:    sec.data = utc_lat[23:16];
			3'd5:    sec.data = utc_lat[15:8];
			3'd6:    sec.data = utc_lat[7:0];
			default: sec.data = 8'(LOAD_LEN);
		endcase
	end

endmodule

//--- hw/pack_load.sv
// payload section, reads the byte memory and forwards what comes back
`timescale 1ns/100ps

module pack_load
	import pack_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  pk_byte_t   load_data,
	output logic       load_rd,
	output load_addr_t load_addr,
	pack_sec_if.sec sec
);

	logic rd_busy;
	logic rd_dly;
	logic last_dly;
	load_addr_t addr;

	// read burst, one address per cycle
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rd_busy <= 1'b0;
			addr    <= '0;
		end else if (sec.fire) begin
			rd_busy <= 1'b1;
			addr    <= '0;
		end else if (rd_busy) begin
			addr <= addr + 4'd1;
			if (addr == load_addr_t'(LOAD_LEN - 1))
				rd_busy <= 1'b0;
		end
	end

	// memory answers one cycle after the strobe
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rd_dly   <= 1'b0;
			last_dly <= 1'b0;
		end else begin
			rd_dly   <= load_rd;
			last_dly <= load_rd && (addr == load_addr_t'(LOAD_LEN - 1));
		end
	end

	assign load_rd   = rd_busy;
	assign load_addr = addr;

	assign sec.vld  = rd_dly;
	assign sec.data = load_data;
	assign sec.done = last_dly;

	// no new burst until the last byte came back
	a_no_overlap: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		sec.fire |-> !load_rd && !rd_dly
	);

endmodule

//--- hw/pack_tail.sv
// tail section, config word then end marker
`timescale 1ns/100ps

module pack_tail
	import pack_pkg::*;
(
	input  logic clk_sys,
	input  logic rst_n,
	input  cfg_t cfg_pkg_en,
	pack_sec_if.sec sec
);

	logic busy;
	logic idx;
	cfg_t cfg_lat;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			idx  <= 1'b0;
		end else if (sec.fire) begin
			busy <= 1'b1;
			idx  <= 1'b0;
		end else if (busy) begin
			idx <= ~idx;
			if (sec.done)
				busy <= 1'b0;
		end
	end

	// config as seen at fire
	always_ff @(posedge clk_sys) begin
		if (sec.fire)
			cfg_lat <= cfg_pkg_en;
	end

	assign sec.vld  = busy;
	assign sec.done = busy && (idx == 1'(TAIL_LEN - 1));
	assign sec.data = idx ? END_MARK : cfg_lat;

endmodule

//--- hw/pack_tx.sv
// output stage, merges section lanes, runs the crc and appends it to the stream
`timescale 1ns/100ps

module pack_tx
	import pack_pkg::*;
(
	input  logic clk_sys,
	input  logic rst_n,
	pack_sec_if.sink head,
	pack_sec_if.sink load,
	pack_sec_if.sink tail,
	pack_sec_if.sec  crc,
	output logic     pk_vld,
	output pk_byte_t pk_data
);

	logic m_vld;
	pk_byte_t m_data;
	crc_t crc_reg;
	logic crc_busy;
	logic crc_idx;

	// one byte of crc-16, msb first
	function automatic crc_t crc_byte(input crc_t c_in, input pk_byte_t d);
		crc_t c;
		logic fb;
		c = c_in;
		for (int i = 7; i >= 0; i--) begin
			fb = c[15] ^ d[i];
			c  = {c[14:0], 1'b0};
			if (fb)
				c = c ^ CRC_POLY;
		end
		return c;
	endfunction

	// --------------------
	// lane merge
	// --------------------

	// only one lane is active at a time
	assign m_vld  = head.vld | load.vld | tail.vld;
	assign m_data = ({8{head.vld}} & head.data) |
		({8{load.vld}} & load.data) |
		({8{tail.vld}} & tail.data);

	// --------------------
	// crc
	// --------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			crc_reg <= CRC_INIT;
		else if (head.fire)
			crc_reg <= CRC_INIT;
		else if (m_vld)
			crc_reg <= crc_byte(crc_reg, m_data);
	end

	// crc lane, high byte then low byte
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			crc_busy <= 1'b0;
			crc_idx  <= 1'b0;
		end else if (crc.fire) begin
			crc_busy <= 1'b1;
			crc_idx  <= 1'b0;
		end else if (crc_busy) begin
			crc_idx <= ~crc_idx;
			if (crc.done)
				crc_busy <= 1'b0;
		end
	end

	assign crc.vld  = crc_busy;
	assign crc.done = crc_busy && (crc_idx == 1'(CRC_LEN - 1));
	assign crc.data = crc_idx ? crc_reg[7:0] : crc_reg[15:8];

	// --------------------
	// output register
	// --------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			pk_vld <= 1'b0;
		else
			pk_vld <= m_vld | crc.vld;
	end

	always_ff @(posedge clk_sys) begin
		if (crc.vld)
			pk_data <= crc.data;
		else if (m_vld)
			pk_data <= m_data;
	end

	// sections never overlap on the stream
	a_one_lane: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		$onehot0({head.vld, load.vld, tail.vld, crc.vld})
	);

endmodule

//--- hw/pack_top.sv
// packer top level, wires the controller, the sections and the output stage
`timescale 1ns/100ps

module pack_top
	import pack_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  cfg_t       cfg_pkg_en,
	input  utc_t       utc_sec,
	input  logic       syn_vld,
	input  pk_byte_t   load_data,
	output logic       load_rd,
	output load_addr_t load_addr,
	output logic       pk_frm,
	output logic       pk_vld,
	output pk_byte_t   pk_data
);

	// one lane per section
	pack_sec_if sec_head ();
	pack_sec_if sec_load ();
	pack_sec_if sec_tail ();
	pack_sec_if sec_crc ();

	pack_main u_main (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.cfg_pkg_en (cfg_pkg_en),
		.syn_vld    (syn_vld),
		.head       (sec_head.ctrl),
		.load       (sec_load.ctrl),
		.tail       (sec_tail.ctrl),
		.crc        (sec_crc.ctrl),
		.pk_frm     (pk_frm)
	);

	pack_head u_head (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.utc_sec (utc_sec),
		.sec     (sec_head.sec)
	);

	pack_load u_load (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.load_data (load_data),
		.load_rd   (load_rd),
		.load_addr (load_addr),
		.sec       (sec_load.sec)
	);

	pack_tail u_tail (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.cfg_pkg_en (cfg_pkg_en),
		.sec        (sec_tail.sec)
	);

	// crc lane is generated inside the output stage
	pack_tx u_tx (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.head    (sec_head.sink),
		.load    (sec_load.sink),
		.tail    (sec_tail.sink),
		.crc     (sec_crc.sec),
		.pk_vld  (pk_vld),
		.pk_data (pk_data)
	);

endmodule

//--- bench/pack_tb_tasks.svh
// helper tasks for the packer testbench to be included inside the bench module

	// --------------------
	// checks
	// --------------------

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_byte(input string name, input pk_byte_t exp, input pk_byte_t got);
		if (got !== exp)
			report_fail($sformatf("CHECK FAILED at time %0t: %s expected %02h got %02h",
				$time, name, exp, got));
	endtask

	task automatic check_crc(input string name, input crc_t exp, input crc_t got);
		if (got !== exp)
			report_fail($sformatf("CHECK FAILED at time %0t: %s expected %04h got %04h",
				$time, name, exp, got));
	endtask

	task automatic check_addr(input string name, input load_addr_t exp, input load_addr_t got);
		if (got !== exp)
			report_fail($sformatf("CHECK FAILED at time %0t: %s expected %0h got %0h",
				$time, name, exp, got));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp)
			report_fail($sformatf("CHECK FAILED at time %0t: %s expected %b got %b",
				$time, name, exp, got));
	endtask

	// --------------------
	// reference frame
	// --------------------

	// crc-16-ccitt with the byte xored into the top and then shifted out
	function automatic crc_t crc_next(input crc_t c_in, input pk_byte_t d);
		crc_t c;
		c = c_in ^ {d, 8'h00};
		repeat (8) begin
			if (c[15])
				c = {c[14:0], 1'b0} ^ CRC_POLY;
			else
				c = {c[14:0], 1'b0};
		end
		return c;
	endfunction

	task automatic build_frame(input utc_t utc, input cfg_t cfg, input frm_cnt_t cnt);
		crc_t c;
		exp_byte.delete();
		exp_byte.push_back(SYNC_HI);
		exp_byte.push_back(SYNC_LO);
		exp_byte.push_back(cnt);
		exp_byte.push_back(utc[31:24]);
		exp_byte.push_back(utc[23:16]);
		exp_byte.push_back(utc[15:8]);
		exp_byte.push_back(utc[7:0]);
		exp_byte.push_back(pk_byte_t'(LOAD_LEN));
		for (int i = 0; i < LOAD_LEN; i++)
			exp_byte.push_back(mem[load_addr_t'(i)]);
		exp_byte.push_back(cfg);
		exp_byte.push_back(END_MARK);
		c = CRC_INIT;
		foreach (exp_byte[i])
			c = crc_next(c, exp_byte[i]);
		exp_crc = c;
		exp_byte.push_back(c[15:8]);
		exp_byte.push_back(c[7:0]);
	endtask

	// --------------------
	// driving and collecting
	// --------------------

	// hold syn_vld high until the controller leaves idle
	task automatic start_frame();
		int waited;
		waited = 0;
		syn_vld = 1'b1;
		@(negedge clk_sys);
		while (!pk_frm) begin
			if (waited == 4)
				report_fail("syn_vld did not start a frame within 4 cycles");
			@(negedge clk_sys);
			waited++;
		end
		syn_vld = 1'b0;
	endtask

	task automatic collect_frame();
		int n;
		int idle;
		n = 0;
		idle = 0;
		rx_byte.delete();
		rx_cyc.delete();
		while (n < FRAME_LEN) begin
			@(negedge clk_sys);
			// once the frame has started pk_frm must stay up
			if (n > 0 || pk_vld)
				check_bit("pk_frm", 1'b1, pk_frm);
			if (pk_vld) begin
				rx_byte.push_back(pk_data);
				rx_cyc.push_back(cyc);
				n++;
				idle = 0;
			end else begin
				idle++;
				if (idle > 40)
					report_fail($sformatf("no byte on pk_vld for 40 cycles after %0d bytes", n));
			end
		end
	endtask

	task automatic compare_frame();
		for (int i = 0; i < FRAME_LEN - CRC_LEN; i++)
			check_byte($sformatf("pk_data byte %0d", i), exp_byte[i], rx_byte[i]);
		check_crc("frame crc", exp_crc, {rx_byte[FRAME_LEN - 2], rx_byte[FRAME_LEN - 1]});
	endtask

//--- bench/pack_tb.sv
// testbench for the frame packer that runs the directed tests against pack_top
`timescale 1ns/100ps

module pack_tb
	import pack_pkg::*;
();

	localparam int CLK_PERIOD = 8;
	localparam int RST_CYCLES = 3;
	// six frames of at most 100 cycles each
	localparam int WD_CYCLES = 6 * 100 + RST_CYCLES;

	logic clk_sys = 1'b0;
	logic rst_n;
	cfg_t cfg_pkg_en;
	utc_t utc_sec;
	logic syn_vld;
	pk_byte_t load_data;
	logic load_rd;
	load_addr_t load_addr;
	logic pk_frm;
	logic pk_vld;
	pk_byte_t pk_data;

	// payload memory model
	pk_byte_t mem [16];
	integer seed;
	logic rd_pend;
	load_addr_t rd_addr;

	// bench state
	int cyc;
	frm_cnt_t exp_cnt;
	pk_byte_t exp_byte [$];
	crc_t exp_crc;
	pk_byte_t rx_byte [$];
	int rx_cyc [$];
	load_addr_t rd_addr_q [$];
	int rd_cyc_q [$];

	pack_top dut0 (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.cfg_pkg_en (cfg_pkg_en),
		.utc_sec    (utc_sec),
		.syn_vld    (syn_vld),
		.load_data  (load_data),
		.load_rd    (load_rd),
		.load_addr  (load_addr),
		.pk_frm     (pk_frm),
		.pk_vld     (pk_vld),
		.pk_data    (pk_data)
	);

	`include "pack_tb_tasks.svh"

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cyc <= cyc + 1;
	end

	// --------------------
	// memory model
	// --------------------

	initial begin
		seed = 12099;
		rd_pend = 1'b0;
		rd_addr = '0;
		load_data = '0;
		for (int i = 0; i < LOAD_LEN; i++)
			mem[load_addr_t'(i)] = pk_byte_t'($random(seed));
	end

	// read data shows up one cycle after the strobe
	always @(negedge clk_sys) begin
		if (rd_pend)
			load_data = mem[rd_addr];
		rd_pend = load_rd;
		rd_addr = load_addr;
	end

	// address trace for the payload test
	always @(negedge clk_sys) begin
		if (load_rd) begin
			rd_addr_q.push_back(load_addr);
			rd_cyc_q.push_back(cyc);
		end
	end

	initial begin
		#(WD_CYCLES * CLK_PERIOD);
		report_fail("watchdog timeout, the tests did not finish in time");
	end

	// --------------------
	// directed tests
	// --------------------

	task automatic test_reset_state();
		repeat (20) begin
			@(negedge clk_sys);
			check_bit("pk_frm", 1'b0, pk_frm);
			check_bit("pk_vld", 1'b0, pk_vld);
			check_bit("load_rd", 1'b0, load_rd);
		end
	endtask

	task automatic test_single_frame();
		utc_sec = 32'h6512_a3c4;
		build_frame(utc_sec, cfg_pkg_en, exp_cnt);
		start_frame();
		collect_frame();
		compare_frame();
		check_byte("frame counter byte", 8'h00, rx_byte[2]);
		exp_cnt++;
	endtask

	task automatic test_back_to_back();
		syn_vld = 1'b1;
		for (int k = 0; k < 3; k++) begin
			// new seconds for every frame are set while the previous one ends
			utc_sec = 32'h6512_a400 + utc_t'(k * 61);
			build_frame(utc_sec, cfg_pkg_en, exp_cnt);
			collect_frame();
			if (k == 2)
				syn_vld = 1'b0;
			compare_frame();
			check_byte("frame counter byte", exp_cnt, rx_byte[2]);
			exp_cnt++;
		end
	endtask

	task automatic test_payload_addr();
		utc_sec = 32'h0000_1234;
		build_frame(utc_sec, cfg_pkg_en, exp_cnt);
		rd_addr_q.delete();
		rd_cyc_q.delete();
		start_frame();
		collect_frame();
		compare_frame();
		exp_cnt++;
		if (rd_addr_q.size() != LOAD_LEN)
			report_fail($sformatf("load_rd was high for %0d cycles instead of %0d",
				rd_addr_q.size(), LOAD_LEN));
		for (int i = 0; i < LOAD_LEN; i++) begin
			check_addr("load_addr", load_addr_t'(i), rd_addr_q[i]);
			check_bit("load_addr on consecutive cycles", 1'b1,
				rd_cyc_q[i] == rd_cyc_q[0] + i);
			// memory cycle plus output register
			check_bit("payload byte two cycles after its address", 1'b1,
				rx_cyc[HEAD_LEN + i] == rd_cyc_q[i] + 2);
			check_byte("payload byte", mem[load_addr_t'(i)], rx_byte[HEAD_LEN + i]);
		end
	endtask

	task automatic test_enable_gating();
		cfg_pkg_en = 8'hfe;
		syn_vld = 1'b1;
		repeat (30) begin
			@(negedge clk_sys);
			check_bit("pk_frm", 1'b0, pk_frm);
			check_bit("load_rd", 1'b0, load_rd);
		end
		syn_vld = 1'b0;
		cfg_pkg_en = 8'h5b;
		utc_sec = 32'hfedc_0042;
		build_frame(utc_sec, cfg_pkg_en, exp_cnt);
		start_frame();
		collect_frame();
		compare_frame();
		check_byte("tail cfg byte", 8'h5b, rx_byte[HEAD_LEN + LOAD_LEN]);
		exp_cnt++;
	endtask

	initial begin
		rst_n = 1'b0;
		cfg_pkg_en = 8'h01;
		utc_sec = '0;
		syn_vld = 1'b0;
		cyc = 0;
		exp_cnt = '0;
		repeat (RST_CYCLES) @(negedge clk_sys);
		rst_n = 1'b1;
		test_reset_state();
		test_single_frame();
		test_back_to_back();
		test_payload_addr();
		test_enable_gating();
		$display("Test passed");
		$finish;
	end

endmodule

//--- compile.f
+incdir+bench
hw/pack_pkg.sv
hw/pack_sec_if.sv
hw/pack_main.sv
hw/pack_head.sv
hw/pack_load.sv
hw/pack_tail.sv
hw/pack_tx.sv
hw/pack_top.sv
bench/pack_tb.sv

//--- Makefile
# Verilator build and run of the packer testbench

TOP := pack_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
